//--- Makefile
VERILATOR  := verilator
FLAGS      := --binary --timing -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP        := tb_soc
RTL_TOP    := soc_top
FILELIST   := src.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# the log decides pass or fail
run: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Everything OK" $(LOG) || { echo "simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/native_bus_if.sv
interface native_bus_if;
   import soc_pkg::*;

   // request side
   logic              valid;
   logic [addr_w-1:0] addr;
   logic [data_w-1:0] wdata;
   // zero strobe means read
   logic [strb_w-1:0] wstrb;

   // response side, ready is a single-cycle pulse
   logic [data_w-1:0] rdata;
   logic              ready;

   // requester
   modport master (output valid, addr, wdata, wstrb, input rdata, ready);

   // responder
   modport slave (input valid, addr, wdata, wstrb, output rdata, ready);

   // observes only the response, for the read mux
   modport resp (input rdata, ready);

endinterface

//--- common/soc_pkg.sv
package soc_pkg;

   ////////////////////
   // bus widths
   ////////////////////
   localparam int data_w = 32;
   localparam int addr_w = 32;
   // one strobe per byte lane
   localparam int strb_w = data_w / 8;

   ////////////////////
   // memory sizes
   ////////////////////
   // byte address widths, word index sits above the two offset bits
   localparam int boot_addr_w = 12;
   localparam int main_addr_w = 14;

   ////////////////////
   // reset timing
   ////////////////////
   // top bit of the counter marks end of power-on, after 1024 cycles
   localparam int por_cnt_w       = 11;
   localparam int soft_rst_cycles = 4;
   localparam int soft_cnt_w      = $clog2(soft_rst_cycles + 1);

   ////////////////////
   // address map
   ////////////////////
   // top word of the space, writing it moves low region to main ram
   localparam logic [addr_w-1:0] switch_addr = 32'hffff_fffc;
   // regions picked by address bits 31..30
   localparam logic [1:0] low_region      = 2'b00;
   localparam logic [1:0] main_alias_base = 2'b01;
   localparam logic [1:0] uart_base       = 2'b10;

   ////////////////////
   // uart
   ////////////////////
   // bit 2 clear is divider, bit 2 set is data
   localparam int uart_sel_bit = 2;
   localparam logic [data_w-1:0] uart_div_reset = 32'd16;
   // start, 8 data, stop
   localparam int uart_frame_w = 10;
   localparam int uart_cnt_w   = $clog2(uart_frame_w);

   // decode result for each request
   typedef enum logic [2:0] {
      target_boot,
      target_main,
      target_uart,
      target_switch,
      target_none
   } target_t;

endpackage

//--- hw/bus_decode.sv
module bus_decode (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      sys_ready,
   input  logic                      mem_sel,
   input  logic                      bus_valid,
   input  logic [soc_pkg::addr_w-1:0] bus_addr,
   input  logic [soc_pkg::data_w-1:0] bus_wdata,
   input  logic [soc_pkg::strb_w-1:0] bus_wstrb,
   native_bus_if.master              boot,
   native_bus_if.master              main,
   native_bus_if.master              uart,
   output soc_pkg::target_t          target,
   output logic                      req_start,
   output logic                      switch_write
);
   import soc_pkg::*;

   logic    req;
   logic    req_q;
   target_t dec;

   // nothing is accepted before power-on completes
   assign req = bus_valid && sys_ready;
   // first cycle of a request, valid drops between requests
   assign req_start = req && !req_q;

   ////////////////////
   // address decode
   ////////////////////
   always_comb begin
      if (bus_addr == switch_addr) begin
         dec = target_switch;
      end else begin
         case (bus_addr[addr_w-1 -: 2])
            // low region follows the memory-select flag
            low_region:      dec = mem_sel ? target_main : target_boot;
            main_alias_base: dec = target_main;
            uart_base:       dec = target_uart;
            default:         dec = target_none;
         endcase
      end
   end

   ////////////////////
   // slave request steering
   ////////////////////
   // only the chosen slave sees valid
   assign boot.valid = req && (dec == target_boot);
   assign main.valid = req && (dec == target_main);
   assign uart.valid = req && (dec == target_uart);

   // payload fans out to all slaves
   assign boot.addr  = bus_addr;
   assign boot.wdata = bus_wdata;
   assign boot.wstrb = bus_wstrb;
   assign main.addr  = bus_addr;
   assign main.wdata = bus_wdata;
   assign main.wstrb = bus_wstrb;
   assign uart.addr  = bus_addr;
   assign uart.wdata = bus_wdata;
   assign uart.wstrb = bus_wstrb;

   // target held for the read mux, switch strobe once per write
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         req_q        <= 1'b0;
         target       <= target_none;
         switch_write <= 1'b0;
      end else begin
         req_q        <= req;
         switch_write <= req_start && (dec == target_switch) && (|bus_wstrb);
         if (req_start) begin
            target <= dec;
         end
      end
   end

endmodule

//--- hw/memory/sram.sv
module sram #(
   parameter int addr_w_bytes = soc_pkg::boot_addr_w
) (
   input  logic        clk,
   input  logic        reset,
   native_bus_if.slave bus
);
   import soc_pkg::*;

   logic [data_w-1:0]         mem [2**(addr_w_bytes-2)];
   logic [addr_w_bytes-3:0]   word_idx;
   logic                      ready_q;
   logic [data_w-1:0]         rdata_q;

   // word index, upper address bits ignored so the space wraps
   assign word_idx = bus.addr[addr_w_bytes-1:2];

   ////////////////////
   // storage
   ////////////////////
   always_ff @(posedge clk) begin
      if (bus.valid && !ready_q) begin
         // strobed bytes only
         for (int b = 0; b < strb_w; b++) begin
            if (bus.wstrb[b]) begin
               mem[word_idx][8*b +: 8] <= bus.wdata[8*b +: 8];
            end
         end
      end
      // read data registered alongside ready
      if (bus.valid) begin
         rdata_q <= mem[word_idx];
      end
   end

   ////////////////////
   // response
   ////////////////////
   // one pulse per request, no repeat while valid is still held
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= bus.valid && !ready_q;
      end
   end

   assign bus.ready = ready_q;
   assign bus.rdata = rdata_q;

endmodule

//--- hw/read_return.sv
module read_return (
   input  logic                       clk,
   input  logic                       reset,
   input  soc_pkg::target_t           target,
   input  logic                       req_start,
   input  logic                       mem_sel,
   native_bus_if.resp                 boot,
   native_bus_if.resp                 main,
   native_bus_if.resp                 uart,
   output logic                       bus_ready,
   output logic [soc_pkg::data_w-1:0] bus_rdata
);
   import soc_pkg::*;

   logic own_q;

   // local response one cycle after the request starts
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         own_q <= 1'b0;
      end else begin
         own_q <= req_start;
      end
   end

   ////////////////////
   // response mux
   ////////////////////
   always_comb begin
      case (target)
         target_boot: begin
            bus_ready = boot.ready;
            bus_rdata = boot.rdata;
         end
         target_main: begin
            bus_ready = main.ready;
            bus_rdata = main.rdata;
         end
         target_uart: begin
            bus_ready = uart.ready;
            bus_rdata = uart.rdata;
         end
         // switch read reports the memory select
         target_switch: begin
            bus_ready = own_q;
            bus_rdata = {{(data_w-1){1'b0}}, mem_sel};
         end
         // unmapped, reads as zero
         default: begin
            bus_ready = own_q;
            bus_rdata = '0;
         end
      endcase
   end

endmodule

//--- hw/reset_ctrl.sv
module reset_ctrl (
   input  logic clk,
   input  logic reset,
   input  logic switch_write,
   output logic sys_ready,
   output logic mem_sel,
   output logic cpu_reset
);
   import soc_pkg::*;

   logic [por_cnt_w-1:0]  por_cnt;
   logic [soft_cnt_w-1:0] soft_cnt;

   ////////////////////
   // power-on counter
   ////////////////////
   // counts up until the top bit sets, then holds
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         por_cnt <= '0;
      end else if (!por_cnt[por_cnt_w-1]) begin
         por_cnt <= por_cnt + 1'b1;
      end
   end

   assign sys_ready = por_cnt[por_cnt_w-1];

   ////////////////////
   // memory switch
   ////////////////////
   // mem_sel is sticky until the next hard reset
   // switch write also loads the core-reset countdown
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         mem_sel  <= 1'b0;
         soft_cnt <= '0;
      end else if (switch_write) begin
         mem_sel  <= 1'b1;
         soft_cnt <= soft_cnt_w'(soft_rst_cycles);
      end else if (soft_cnt != '0) begin
         soft_cnt <= soft_cnt - 1'b1;
      end
   end

   // core held in reset during power-on and during the switch pulse
   assign cpu_reset = !sys_ready || (soft_cnt != '0);

endmodule

//--- hw/soc_top.sv
module soc_top (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       bus_valid,
   input  logic [soc_pkg::addr_w-1:0] bus_addr,
   input  logic [soc_pkg::data_w-1:0] bus_wdata,
   input  logic [soc_pkg::strb_w-1:0] bus_wstrb,
   output logic [soc_pkg::data_w-1:0] bus_rdata,
   output logic                       bus_ready,
   output logic                       ser_tx,
   output logic                       sys_ready,
   output logic                       cpu_reset,
   output logic                       mem_sel
);
   import soc_pkg::*;

   target_t target;
   logic    req_start;
   logic    switch_write;

   // one bus per slave
   native_bus_if boot_bus ();
   native_bus_if main_bus ();
   native_bus_if uart_bus ();

   ////////////////////
   // decode and reset
   ////////////////////
   bus_decode u_decode (
      .clk          (clk),
      .reset        (reset),
      .sys_ready    (sys_ready),
      .mem_sel      (mem_sel),
      .bus_valid    (bus_valid),
      .bus_addr     (bus_addr),
      .bus_wdata    (bus_wdata),
      .bus_wstrb    (bus_wstrb),
      .boot         (boot_bus.master),
      .main         (main_bus.master),
      .uart         (uart_bus.master),
      .target       (target),
      .req_start    (req_start),
      .switch_write (switch_write)
   );

   reset_ctrl u_reset_ctrl (
      .clk          (clk),
      .reset        (reset),
      .switch_write (switch_write),
      .sys_ready    (sys_ready),
      .mem_sel      (mem_sel),
      .cpu_reset    (cpu_reset)
   );

   ////////////////////
   // slaves
   ////////////////////
   sram #(.addr_w_bytes(boot_addr_w)) u_boot_mem (
      .clk   (clk),
      .reset (reset),
      .bus   (boot_bus.slave)
   );

   sram #(.addr_w_bytes(main_addr_w)) u_main_mem (
      .clk   (clk),
      .reset (reset),
      .bus   (main_bus.slave)
   );

   uart_tx u_uart (
      .clk    (clk),
      .reset  (reset),
      .bus    (uart_bus.slave),
      .ser_tx (ser_tx)
   );

   // response back to the master
   read_return u_read_return (
      .clk       (clk),
      .reset     (reset),
      .target    (target),
      .req_start (req_start),
      .mem_sel   (mem_sel),
      .boot      (boot_bus.resp),
      .main      (main_bus.resp),
      .uart      (uart_bus.resp),
      .bus_ready (bus_ready),
      .bus_rdata (bus_rdata)
   );

endmodule

//--- hw/uart/uart_tx.sv
module uart_tx (
   input  logic        clk,
   input  logic        reset,
   native_bus_if.slave bus,
   output logic        ser_tx
);
   import soc_pkg::*;

   logic                    is_data;
   logic                    is_write;
   logic                    accept;
   logic                    ready_q;
   logic [data_w-1:0]       rdata_q;
   logic [data_w-1:0]       div_q;
   logic [data_w-1:0]       baud_cnt;
   logic [uart_cnt_w-1:0]   bit_cnt;
   logic [uart_frame_w-1:0] shreg;
   logic                    busy;

   assign is_data  = bus.addr[uart_sel_bit];
   assign is_write = |bus.wstrb;
   // data write stalls until the frame in flight is done
   assign accept   = bus.valid && !ready_q && !(is_data && is_write && busy);

   ////////////////////
   // bus registers
   ////////////////////
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         ready_q <= 1'b0;
         div_q   <= uart_div_reset;
      end else begin
         ready_q <= accept;
         // zero divider would never advance, force one
         if (accept && is_write && !is_data) begin
            div_q <= (bus.wdata == '0) ? data_w'(1) : bus.wdata;
         end
      end
   end

   // status read shows busy in bit 0
   always_ff @(posedge clk) begin
      if (bus.valid) begin
         rdata_q <= is_data ? {{(data_w-1){1'b0}}, busy} : div_q;
      end
   end

   assign bus.ready = ready_q;
   assign bus.rdata = rdata_q;

   ////////////////////
   // 8N1 shifter
   ////////////////////
   // ones shift in behind the frame so the line idles high
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         busy     <= 1'b0;
         shreg    <= '1;
         bit_cnt  <= '0;
         baud_cnt <= '0;
      end else if (accept && is_write && is_data) begin
         busy     <= 1'b1;
         shreg    <= {1'b1, bus.wdata[7:0], 1'b0};
         bit_cnt  <= '0;
         baud_cnt <= div_q - 1'b1;
      end else if (busy) begin
         if (baud_cnt == '0) begin
            // end of one bit time
            baud_cnt <= div_q - 1'b1;
            shreg    <= {1'b1, shreg[uart_frame_w-1:1]};
            bit_cnt  <= bit_cnt + 1'b1;
            // stop bit done
            if (bit_cnt == uart_cnt_w'(uart_frame_w - 1)) begin
               busy <= 1'b0;
            end
         end else begin
            baud_cnt <= baud_cnt - 1'b1;
         end
      end
   end

   assign ser_tx = shreg[0];

endmodule

//--- src.f
common/soc_pkg.sv
common/native_bus_if.sv
hw/bus_decode.sv
hw/reset_ctrl.sv
hw/memory/sram.sv
hw/uart/uart_tx.sv
hw/read_return.sv
hw/soc_top.sv
verification/uart_rx_model.sv
verification/tb_soc.sv

//--- verification/tb_soc.sv
module tb_soc;
   timeunit 1ns;
   timeprecision 1ps;

   // address map as seen by the processor
   localparam logic [31:0] switch_word = 32'hffff_fffc;
   localparam logic [31:0] uart_div_addr = 32'h8000_0000;
   localparam logic [31:0] uart_data_addr = 32'h8000_0004;

   logic        clk = 1'b0;
   logic        reset;
   logic        bus_valid;
   logic [31:0] bus_addr;
   logic [31:0] bus_wdata;
   logic [3:0]  bus_wstrb;
   logic [31:0] bus_rdata;
   logic        bus_ready;
   logic        ser_tx;
   logic        sys_ready;
   logic        cpu_reset;
   logic        mem_sel;
   logic        rx_enable;
   logic        rx_valid;
   logic [7:0]  rx_data;
   logic        rx_timeout;
   logic        rx_frame_err;
   int          uart_div;
   int          cycle = 0;
   logic [7:0]  rx_bytes [$];
   logic [31:0] lfsr = 32'h89d7;

   // reference state
   logic [31:0] boot_model [1024];
   logic [31:0] main_model [4096];
   logic        model_sel;
   logic [31:0] model_div;

   soc_top dut (
      .clk       (clk),
      .reset     (reset),
      .bus_valid (bus_valid),
      .bus_addr  (bus_addr),
      .bus_wdata (bus_wdata),
      .bus_wstrb (bus_wstrb),
      .bus_rdata (bus_rdata),
      .bus_ready (bus_ready),
      .ser_tx    (ser_tx),
      .sys_ready (sys_ready),
      .cpu_reset (cpu_reset),
      .mem_sel   (mem_sel)
   );

   uart_rx_model rx (
      .clk          (clk),
      .ser_tx       (ser_tx),
      .enable       (rx_enable),
      .divider      (uart_div),
      .rx_valid     (rx_valid),
      .rx_data      (rx_data),
      .rx_timeout   (rx_timeout),
      .rx_frame_err (rx_frame_err)
   );

   always #20 clk = ~clk;

   // cycle count for the uart timing check
   always @(posedge clk) cycle <= cycle + 1;

   ////////////////////
   // helpers
   ////////////////////
   // galois lfsr, one step per bit taken
   function automatic logic [31:0] random_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         r = {r[30:0], lfsr[0]};
         lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
      end
      return r;
   endfunction

   function automatic logic [31:0] merge(input logic [31:0] old, input logic [31:0] data,
                                         input logic [3:0] strb);
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) old[8*b +: 8] = data[8*b +: 8];
      end
      return old;
   endfunction

   // expected read data from the memory map
   function automatic logic [31:0] ref_read(input logic [31:0] addr);
      if (addr == switch_word) return {31'b0, model_sel};
      case (addr[31:30])
         2'b00:   return model_sel ? main_model[addr[13:2]] : boot_model[addr[11:2]];
         2'b01:   return main_model[addr[13:2]];
         // divider only, status reads checked apart
         2'b10:   return model_div;
         default: return 32'h0;
      endcase
   endfunction

   function automatic void ref_write(input logic [31:0] addr, input logic [31:0] data,
                                     input logic [3:0] strb);
      if (addr == switch_word) begin
         model_sel = 1'b1;
      end else if (addr[31:30] == 2'b00 && !model_sel) begin
         boot_model[addr[11:2]] = merge(boot_model[addr[11:2]], data, strb);
      end else if (addr[31:30] == 2'b00 || addr[31:30] == 2'b01) begin
         main_model[addr[13:2]] = merge(main_model[addr[13:2]], data, strb);
      end else if (addr[31:30] == 2'b10 && !addr[2]) begin
         model_div = (data == 32'h0) ? 32'h1 : data;
      end
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) abort_run($sformatf("error %s got %h expected %h", name, got, exp));
   endtask

   // one handshake, valid held until ready
   task automatic access(input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [3:0] wstrb, output logic [31:0] rdata, output int cycles);
      @(negedge clk);
      bus_valid = 1'b1;
      bus_addr  = addr;
      bus_wdata = wdata;
      bus_wstrb = wstrb;
      cycles    = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!bus_ready && cycles < 1000);
      if (!bus_ready) abort_run($sformatf("no ready for the access to %h", addr));
      rdata     = bus_rdata;
      bus_valid = 1'b0;
   endtask

   task automatic mem_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
      logic [31:0] rd;
      int          cyc;
      access(addr, data, strb, rd, cyc);
      check("bus_ready latency", 32'(cyc), 32'd1);
      ref_write(addr, data, strb);
   endtask

   task automatic checked_read(input logic [31:0] addr);
      logic [31:0] rd;
      int          cyc;
      access(addr, 32'h0, 4'h0, rd, cyc);
      check("bus_ready latency", 32'(cyc), 32'd1);
      check($sformatf("bus_rdata at %h", addr), rd, ref_read(addr));
   endtask

   // bytes from the serial monitor
   always @(posedge clk) begin
      if (rx_valid) rx_bytes.push_back(rx_data);
      if (rx_timeout) abort_run("uart monitor saw no start bit in time");
      if (rx_frame_err) abort_run("uart monitor saw a broken start or stop bit");
   end

   ////////////////////
   // test sequence
   ////////////////////
   initial begin
      logic [31:0] addrs [16];
      logic [31:0] rd;
      logic [7:0]  tx_bytes [2];
      logic [3:0]  strb;
      logic        cpu_before;
      int          n;
      int          cyc;
      int          t_first;
      int          high;
      reset     = 1'b1;
      bus_valid = 1'b0;
      bus_addr  = '0;
      bus_wdata = '0;
      bus_wstrb = '0;
      rx_enable = 1'b0;
      uart_div  = 16;
      model_sel = 1'b0;
      model_div = 32'd16;
      cpu_before = 1'b1;
      repeat (4) @(negedge clk);
      check("sys_ready", 32'(sys_ready), 32'd0);
      check("mem_sel", 32'(mem_sel), 32'd0);
      check("bus_ready", 32'(bus_ready), 32'd0);
      check("cpu_reset", 32'(cpu_reset), 32'd1);
      check("ser_tx", 32'(ser_tx), 32'd1);
      reset = 1'b0;

      // power-on count, rising edges since reset fell
      n = 0;
      while (!sys_ready && n < 1100) begin
         cpu_before = cpu_reset;
         @(negedge clk);
         n++;
      end
      if (!sys_ready) abort_run("sys_ready never rose after reset");
      check("sys_ready edge count", 32'(n), 32'd1024);
      check("cpu_reset", 32'(cpu_reset), 32'd0);
      check("cpu_reset before ready", 32'(cpu_before), 32'd1);

      // main ram through the alias, random strobes
      for (int i = 0; i < 16; i++) begin
         addrs[i] = 32'h4000_0000 | (random_bits(12) << 2);
         mem_write(addrs[i], random_bits(32), 4'hf);
         strb = 4'(random_bits(4));
         if (strb == 4'h0) strb = 4'h8;
         mem_write(addrs[i], random_bits(32), strb);
      end
      for (int i = 0; i < 16; i++) checked_read(addrs[i]);

      // boot and main patterns, then switch
      for (int i = 0; i < 4; i++) begin
         mem_write(32'h0000_0000 + 4 * i, 32'hb007_0000 + i, 4'hf);
         mem_write(32'h4000_0000 + 4 * i, 32'h3a1c_0000 + i, 4'hf);
      end
      for (int i = 0; i < 4; i++) checked_read(32'h0000_0000 + 4 * i);
      mem_write(switch_word, 32'h1, 4'hf);
      high = 0;
      for (int i = 0; i < 8; i++) begin
         @(negedge clk);
         if (i == 0) check("cpu_reset after switch", 32'(cpu_reset), 32'd1);
         if (cpu_reset) high++;
      end
      check("cpu_reset pulse cycles", 32'(high), 32'd4);
      check("mem_sel", 32'(mem_sel), 32'd1);
      checked_read(switch_word);
      for (int i = 0; i < 4; i++) checked_read(32'h0000_0000 + 4 * i);

      // uart, two frames back to back
      uart_div  = 8;
      rx_enable = 1'b1;
      mem_write(uart_div_addr, 32'd8, 4'hf);
      checked_read(uart_div_addr);
      tx_bytes[0] = 8'(random_bits(8));
      tx_bytes[1] = 8'(random_bits(8));
      access(uart_data_addr, {24'h0, tx_bytes[0]}, 4'h1, rd, cyc);
      check("bus_ready latency", 32'(cyc), 32'd1);
      t_first = cycle;
      access(uart_data_addr, {24'h0, tx_bytes[1]}, 4'h1, rd, cyc);
      if (cycle - t_first < 10 * uart_div) begin
         abort_run("second uart write finished before the first frame ended");
      end
      // second frame now in flight
      access(uart_data_addr, 32'h0, 4'h0, rd, cyc);
      check("uart status busy", {31'b0, rd[0]}, 32'd1);
      n = 0;
      while (rx_bytes.size() < 2 && n < 40 * uart_div) begin
         @(negedge clk);
         n++;
      end
      if (rx_bytes.size() < 2) abort_run("uart monitor did not receive both bytes");
      check("ser_tx byte 0", 32'(rx_bytes[0]), 32'(tx_bytes[0]));
      check("ser_tx byte 1", 32'(rx_bytes[1]), 32'(tx_bytes[1]));
      rx_enable = 1'b0;

      // unmapped region reads zero, writes go nowhere
      checked_read(32'hc000_0010);
      mem_write(32'hc000_0000, 32'h5555_aaaa, 4'hf);
      checked_read(32'h4000_0000);
      checked_read(32'h0000_0000);
      checked_read(32'hc000_0000);

      $display("Everything OK");
      $finish;
   end

endmodule

//--- verification/uart_rx_model.sv
module uart_rx_model (
   input  logic       clk,
   input  logic       ser_tx,
   input  logic       enable,
   input  int         divider,
   output logic       rx_valid,
   output logic [7:0] rx_data,
   output logic       rx_timeout,
   output logic       rx_frame_err
);
   timeunit 1ns;
   timeprecision 1ps;

   // idle falling edges allowed before a start bit
   localparam int idle_limit = 4096;

   int         idle_cnt;
   logic [7:0] shift;

   task automatic skip_edges(input int n);
      repeat (n) @(negedge clk);
   endtask

   initial begin
      rx_valid     = 1'b0;
      rx_data      = '0;
      rx_timeout   = 1'b0;
      rx_frame_err = 1'b0;
      idle_cnt     = 0;
      forever begin
         @(negedge clk);
         rx_valid = 1'b0;
         if (!enable || ser_tx) begin
            // idle time only counts while armed
            idle_cnt = enable ? idle_cnt + 1 : 0;
            if (idle_cnt > idle_limit) begin
               rx_timeout = 1'b1;
            end
         end else begin
            idle_cnt = 0;
            // middle of the start bit
            skip_edges(divider / 2);
            if (ser_tx) begin
               rx_frame_err = 1'b1;
            end
            // lsb first
            for (int i = 0; i < 8; i++) begin
               skip_edges(divider);
               shift[i] = ser_tx;
            end
            skip_edges(divider);
            if (!ser_tx) begin
               rx_frame_err = 1'b1;
            end
            rx_data  = shift;
            rx_valid = 1'b1;
         end
      end
   end

endmodule
